// File: design/axis_defines.svh
`ifndef AXIS_DEFINES_SVH
`define AXIS_DEFINES_SVH

// data widths of the three stream links
`define AXIS_WIDE_W 64
`define AXIS_BYTE_W 8
`define AXIS_WORD_W 32

// one keep bit per byte lane
`define AXIS_WIDE_KEEP_W (`AXIS_WIDE_W / `AXIS_BYTE_W)
`define AXIS_WORD_KEEP_W (`AXIS_WORD_W / `AXIS_BYTE_W)

// bytes gathered into each output word
`define AXIS_PACK_RATIO 4

`endif

// File: design/axis_beat_pkg.sv
package axis_beat_pkg;

  `include "axis_defines.svh"

  typedef logic [`AXIS_WIDE_W-1:0] wide_data_t;
  typedef logic [`AXIS_WORD_W-1:0] word_data_t;
  typedef logic [`AXIS_BYTE_W-1:0] byte_data_t;

  typedef logic [`AXIS_WIDE_KEEP_W-1:0] wide_keep_t;
  typedef logic [`AXIS_WORD_KEEP_W-1:0] word_keep_t;

  typedef logic [$clog2(`AXIS_WIDE_KEEP_W)-1:0] lane_idx_t; // byte lane within a wide beat

  typedef struct packed {
    wide_data_t data;
    wide_keep_t keep;
    logic       last;
    logic       user;
  } wide_beat_t;

  // a byte beat is always whole, so no keep
  typedef struct packed {
    byte_data_t data;
    logic       last;
    logic       user;
  } byte_beat_t;

  typedef struct packed {
    word_data_t data;
    word_keep_t keep;
    logic       last;
    logic       user;
  } word_beat_t;

endpackage

// File: design/adapt_state_pkg.sv
package adapt_state_pkg;

  `include "axis_defines.svh"

  typedef enum logic {
    SER_IDLE, // waiting for a wide beat
    SER_EMIT  // walking the byte lanes
  } ser_state_t;

  typedef enum logic {
    PACK_COLLECT, // filling lane slots
    PACK_FLUSH    // word offered downstream
  } pack_state_t;

endpackage

// File: design/axis_skid_reg.sv
`timescale 1ns/1ps

module axis_skid_reg #(
  parameter int WIDTH = 10
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [WIDTH-1:0] out_q;
  logic [WIDTH-1:0] spare_q;
  logic             out_valid_q;
  logic             spare_valid_q;
  logic             in_ready_q;
  logic             in_fire;
  logic             out_drain;
  logic             spare_load;
  logic             spare_valid_nxt;
  logic             out_valid_nxt;

  assign in_ready  = in_ready_q;
  assign out_data  = out_q;
  assign out_valid = out_valid_q;

  assign in_fire   = in_valid & in_ready_q;
  assign out_drain = out_valid_q & out_ready;

  // park the beat when the output entry is held
  assign spare_load      = in_fire & out_valid_q & ~out_ready;
  assign spare_valid_nxt = spare_load | (spare_valid_q & ~out_drain);
  assign out_valid_nxt   = in_fire | spare_valid_q | (out_valid_q & ~out_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q   <= 1'b0;
      spare_valid_q <= 1'b0;
      in_ready_q    <= 1'b0;
    end else begin
      out_valid_q   <= out_valid_nxt;
      spare_valid_q <= spare_valid_nxt;
      in_ready_q    <= ~spare_valid_nxt; // low while the spare is occupied
    end
  end

  always_ff @(posedge clk) begin
    if (spare_load) begin
      spare_q <= in_data;
    end
    if (in_fire && !spare_load) begin
      out_q <= in_data;
    end else if (out_drain && spare_valid_q) begin
      out_q <= spare_q; // refill from spare
    end
  end

endmodule

// File: design/axis_serializer.sv
`timescale 1ns/1ps

`include "axis_defines.svh"

module axis_serializer (
  input  logic                      clk,
  input  logic                      rst,
  input  axis_beat_pkg::wide_beat_t s_beat,
  input  logic                      s_valid,
  output logic                      s_ready,
  output axis_beat_pkg::byte_beat_t m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  adapt_state_pkg::ser_state_t state;
  axis_beat_pkg::wide_beat_t   beat_q;
  axis_beat_pkg::lane_idx_t    lane;
  axis_beat_pkg::lane_idx_t    next_lane;
  axis_beat_pkg::byte_beat_t   byte_beat;
  logic                        byte_valid;
  logic                        byte_ready;
  logic                        final_byte;
  logic                        s_ready_q;
  logic                        s_fire;

  assign s_ready = s_ready_q;
  assign s_fire  = s_valid & s_ready_q;

  assign next_lane = lane + 1'b1;

  // top lane, or keep runs out at the next lane
  assign final_byte = (&lane) || !beat_q.keep[next_lane];

  assign byte_valid = (state == adapt_state_pkg::SER_EMIT);

  always_comb begin
    byte_beat.data = beat_q.data[lane*`AXIS_BYTE_W +: `AXIS_BYTE_W];
    byte_beat.last = beat_q.last & final_byte; // only on the closing byte
    byte_beat.user = beat_q.user & final_byte;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= adapt_state_pkg::SER_IDLE;
      lane      <= '0;
      s_ready_q <= 1'b0;
    end else begin
      case (state)
        adapt_state_pkg::SER_IDLE: begin
          s_ready_q <= 1'b1;
          if (s_fire) begin
            state     <= adapt_state_pkg::SER_EMIT;
            lane      <= '0;
            s_ready_q <= 1'b0;
          end
        end
        adapt_state_pkg::SER_EMIT: begin
          if (byte_ready) begin
            if (final_byte) begin
              state     <= adapt_state_pkg::SER_IDLE;
              s_ready_q <= 1'b1; // next beat may come in
            end else begin
              lane <= next_lane;
            end
          end
        end
        default: begin
          state     <= adapt_state_pkg::SER_IDLE;
          s_ready_q <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      beat_q <= s_beat;
    end
  end

  axis_skid_reg #(
    .WIDTH ($bits(axis_beat_pkg::byte_beat_t))
  ) u_skid (
    .clk       (clk),
    .rst       (rst),
    .in_data   (byte_beat),
    .in_valid  (byte_valid),
    .in_ready  (byte_ready),
    .out_data  (m_beat),
    .out_valid (m_valid),
    .out_ready (m_ready)
  );

endmodule

// File: design/axis_packer.sv
`timescale 1ns/1ps

`include "axis_defines.svh"

module axis_packer (
  input  logic                      clk,
  input  logic                      rst,
  input  axis_beat_pkg::byte_beat_t s_beat,
  input  logic                      s_valid,
  output logic                      s_ready,
  output axis_beat_pkg::word_beat_t m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  adapt_state_pkg::pack_state_t         state;
  axis_beat_pkg::word_data_t            data_q;
  axis_beat_pkg::word_keep_t            keep_q;
  logic [$clog2(`AXIS_PACK_RATIO)-1:0]  fill;
  logic                                 last_q;
  logic                                 user_q;
  logic                                 s_fire;
  axis_beat_pkg::word_beat_t            word_beat;
  logic                                 word_valid;
  logic                                 word_ready;

  assign s_ready    = (state == adapt_state_pkg::PACK_COLLECT);
  assign s_fire     = s_valid & s_ready;
  assign word_valid = (state == adapt_state_pkg::PACK_FLUSH);

  // unfilled lanes read as zero
  always_comb begin
    for (int i = 0; i < `AXIS_PACK_RATIO; i++) begin
      word_beat.data[i*`AXIS_BYTE_W +: `AXIS_BYTE_W] =
        keep_q[i] ? data_q[i*`AXIS_BYTE_W +: `AXIS_BYTE_W] : '0;
    end
    word_beat.keep = keep_q;
    word_beat.last = last_q;
    word_beat.user = user_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= adapt_state_pkg::PACK_COLLECT;
      fill   <= '0;
      keep_q <= '0;
      last_q <= 1'b0;
      user_q <= 1'b0;
    end else begin
      case (state)
        adapt_state_pkg::PACK_COLLECT: begin
          if (s_fire) begin
            keep_q[fill] <= 1'b1;
            fill         <= fill + 1'b1;
            if (fill == `AXIS_PACK_RATIO - 1 || s_beat.last) begin
              state  <= adapt_state_pkg::PACK_FLUSH; // full word or early end
              last_q <= s_beat.last;
              user_q <= s_beat.user;
            end
          end
        end
        adapt_state_pkg::PACK_FLUSH: begin
          if (word_ready) begin
            state  <= adapt_state_pkg::PACK_COLLECT;
            fill   <= '0;
            keep_q <= '0;
            last_q <= 1'b0;
            user_q <= 1'b0;
          end
        end
        default: state <= adapt_state_pkg::PACK_COLLECT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      data_q[fill*`AXIS_BYTE_W +: `AXIS_BYTE_W] <= s_beat.data;
    end
  end

  axis_skid_reg #(
    .WIDTH ($bits(axis_beat_pkg::word_beat_t))
  ) u_skid (
    .clk       (clk),
    .rst       (rst),
    .in_data   (word_beat),
    .in_valid  (word_valid),
    .in_ready  (word_ready),
    .out_data  (m_beat),
    .out_valid (m_valid),
    .out_ready (m_ready)
  );

endmodule

// File: design/axis_width_bridge.sv
`timescale 1ns/1ps

module axis_width_bridge (
  input  logic                      clk,
  input  logic                      rst,
  input  axis_beat_pkg::wide_beat_t s_beat,
  input  logic                      s_valid,
  output logic                      s_ready,
  output axis_beat_pkg::word_beat_t m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  axis_beat_pkg::byte_beat_t mid_beat; // byte stream between the stages
  logic                      mid_valid;
  logic                      mid_ready;

  axis_serializer u_serializer (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (mid_beat),
    .m_valid (mid_valid),
    .m_ready (mid_ready)
  );

  axis_packer u_packer (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (mid_beat),
    .s_valid (mid_valid),
    .s_ready (mid_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

endmodule

// File: test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0; // released on a rising edge
  end

endmodule

// File: test/tb_axis_width_bridge.sv
`timescale 1ns/1ps

`include "axis_defines.svh"

module tb_axis_width_bridge;

  localparam int STALL_PERIOD  = 33; // m_ready low 32 cycles, then high for one
  localparam int STALL_RUN_MIN = 16; // longer than any wait without back-pressure

  logic                      clk;
  logic                      rst;
  axis_beat_pkg::wide_beat_t s_beat;
  logic                      s_valid;
  logic                      s_ready;
  axis_beat_pkg::word_beat_t m_beat;
  logic                      m_valid;
  logic                      m_ready;

  string row_name[$];
  int    row_len[$];
  bit    row_user[$];
  int    row_duty[$];  // percent m_ready high, 0 for long stalls
  bit    row_stall[$]; // expect s_ready held off by the full chain

  axis_beat_pkg::byte_data_t pkt[$];
  axis_beat_pkg::word_beat_t exp_q[$];

  int cycle_count = 0;
  int timeout_limit = 0;

  clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  axis_width_bridge dut (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic add_row(input string name, input int len, input bit user,
                         input int duty, input bit stall);
    row_name.push_back(name);
    row_len.push_back(len);
    row_user.push_back(user);
    row_duty.push_back(duty);
    row_stall.push_back(stall);
  endtask

  task automatic load_table();
    add_row("full_4",         4,  1'b0, 100, 1'b0);
    add_row("full_8",         8,  1'b1, 100, 1'b0);
    add_row("full_16",        16, 1'b0, 100, 1'b0);
    add_row("short_1",        1,  1'b1, 100, 1'b0);
    add_row("short_5",        5,  1'b0, 100, 1'b0);
    add_row("short_7",        7,  1'b1, 100, 1'b0);
    add_row("mid_partial_11", 11, 1'b0, 30,  1'b0); // partial keep on the second beat
    add_row("long_21",        21, 1'b1, 100, 1'b0);
    add_row("duty30_13",      13, 1'b1, 30,  1'b0);
    add_row("duty30_21",      21, 1'b0, 30,  1'b0);
    add_row("stall_21",       21, 1'b1, 0,   1'b1);
    add_row("stall_9",        9,  1'b0, 0,   1'b0);
  endtask

  function automatic logic next_ready(input int duty, input int n);
    if (duty == 0) begin
      return (n % STALL_PERIOD) == STALL_PERIOD - 1;
    end
    return $urandom_range(0, 99) < duty;
  endfunction

  task automatic build_packet(input int len);
    pkt.delete();
    for (int i = 0; i < len; i++) begin
      pkt.push_back(axis_beat_pkg::byte_data_t'($urandom_range(0, 255)));
    end
  endtask

  // packet bytes regrouped four to a word
  task automatic build_expected(input bit user);
    int                        n_words;
    axis_beat_pkg::word_beat_t w;
    exp_q.delete();
    n_words = (pkt.size() + `AXIS_PACK_RATIO - 1) / `AXIS_PACK_RATIO;
    for (int g = 0; g < n_words; g++) begin
      w = '0;
      for (int k = 0; k < `AXIS_PACK_RATIO; k++) begin
        if (g * `AXIS_PACK_RATIO + k < pkt.size()) begin
          w.data[k*`AXIS_BYTE_W +: `AXIS_BYTE_W] = pkt[g*`AXIS_PACK_RATIO + k];
          w.keep[k] = 1'b1;
        end
      end
      w.last = (g == n_words - 1);
      w.user = user && (g == n_words - 1);
      exp_q.push_back(w);
    end
  endtask

  task automatic send_packet(input bit user);
    int                        n_beats;
    axis_beat_pkg::wide_beat_t b;
    n_beats = (pkt.size() + `AXIS_WIDE_KEEP_W - 1) / `AXIS_WIDE_KEEP_W;
    for (int i = 0; i < n_beats; i++) begin
      b.data = {$urandom, $urandom}; // empty lanes carry junk
      b.keep = '0;
      for (int l = 0; l < `AXIS_WIDE_KEEP_W; l++) begin
        if (i * `AXIS_WIDE_KEEP_W + l < pkt.size()) begin
          b.data[l*`AXIS_BYTE_W +: `AXIS_BYTE_W] = pkt[i*`AXIS_WIDE_KEEP_W + l];
          b.keep[l] = 1'b1;
        end
      end
      b.last = (i == n_beats - 1);
      b.user = user && (i == n_beats - 1);
      s_beat  <= b;
      s_valid <= 1'b1;
      @(posedge clk);
      while (!s_ready) @(posedge clk);
    end
    s_valid <= 1'b0;
  endtask

  task automatic collect_words(input string name, input int duty, output int max_run);
    int                        n;
    int                        run;
    axis_beat_pkg::word_beat_t exp_w;
    n       = 0;
    run     = 0;
    max_run = 0;
    m_ready <= next_ready(duty, n);
    while (exp_q.size() > 0) begin
      @(posedge clk);
      n++;
      if (s_valid && !s_ready) begin
        run++; // source waiting on the chain
        if (run > max_run) begin
          max_run = run;
        end
      end else begin
        run = 0;
      end
      if (m_valid && m_ready) begin
        exp_w = exp_q.pop_front();
        check_value(name, exp_w, m_beat);
      end
      m_ready <= next_ready(duty, n);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      abort_run("timeout: output stream stalled");
    end
  end

  initial begin
    int max_run;
    int total;
    void'($urandom(40049));
    s_valid  = 1'b0;
    s_beat   = '0;
    m_ready  = 1'b0;
    load_table();
    total = 0;
    foreach (row_len[i]) begin
      total += row_len[i];
    end
    timeout_limit = 40 * total;

    wait (rst === 1'b0);
    @(posedge clk);
    check_value("reset m_valid", 64'd0, m_valid); // first cycle out of reset
    check_value("reset s_ready", 64'd0, s_ready);

    for (int r = 0; r < row_name.size(); r++) begin
      build_packet(row_len[r]);
      build_expected(row_user[r]);
      fork
        send_packet(row_user[r]);
        collect_words(row_name[r], row_duty[r], max_run);
      join
      if (row_stall[r]) begin
        check_value({row_name[r], " backpressure"}, 64'd1, max_run > STALL_RUN_MIN);
      end
    end

    // nothing extra may follow the last packet
    m_ready <= 1'b1;
    repeat (16) begin
      @(posedge clk);
      check_value("idle m_valid", 64'd0, m_valid);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: sources.f
+incdir+design
design/axis_beat_pkg.sv
design/adapt_state_pkg.sv
design/axis_skid_reg.sv
design/axis_serializer.sv
design/axis_packer.sv
design/axis_width_bridge.sv
test/clk_gen.sv
test/tb_axis_width_bridge.sv

// File: Bender.yml
package:
  name: axis_width_bridge

export_include_dirs:
  - design

sources:
  - files:
      - design/axis_beat_pkg.sv
      - design/adapt_state_pkg.sv
      - design/axis_skid_reg.sv
      - design/axis_serializer.sv
      - design/axis_packer.sv
      - design/axis_width_bridge.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/tb_axis_width_bridge.sv
